// ==== build.f ====
design/isa_pkg.sv
design/ctrl_pkg.sv
design/decode_if.sv
design/phase_decode.sv
design/alu_op_decode.sv
design/branch_decode.sv
design/transfer_decode.sv
design/ctrl_select.sv
design/controller.sv
testbench/controller_tb.sv

// ==== design/alu_op_decode.sv ====
`timescale 1ns/100ps

module alu_op_decode (
        decode_if.dst               dec,
        output ctrl_pkg::ctrl_word_t word,
        output logic                hit
);
        import isa_pkg::*;
        import ctrl_pkg::*;

        assign hit = (dec.phase == PH_EXEC) && (dec.opcode <= OP_ROR);

        always_comb begin
                word.dest_reg   = dec.dest_f;
                word.sour_reg   = dec.sour_f;
                word.offset     = '0;
                word.rec        = REC_NONE;
                word.wr         = 1'b1;
                word.sst        = SST_ALU;
                word.sci        = SCI_ZERO;
                word.alu_in_sel = IN_NONE;
                word.wb         = WB_REG;

                case (dec.opcode)
                        OP_ADD:  word.alu_func = 4'h0;
                        OP_SUB:  word.alu_func = 4'h1;
                        OP_AND:  word.alu_func = 4'h2;
                        OP_CMP:  word.alu_func = 4'h1;  // sub, flags only
                        OP_XOR:  word.alu_func = 4'h4;
                        OP_TEST: word.alu_func = 4'h2;  // and, flags only
                        OP_OR:   word.alu_func = 4'h3;
                        OP_MVRR: word.alu_func = 4'h0;
                        OP_DEC:  word.alu_func = 4'h1;
                        OP_INC:  word.alu_func = 4'h0;
                        OP_SHL:  word.alu_func = 4'h5;
                        OP_SHR:  word.alu_func = 4'h6;
                        OP_ADC:  word.alu_func = 4'h0;
                        OP_SBB:  word.alu_func = 4'h1;
                        OP_NOT:  word.alu_func = 4'h7;
                        OP_DIV:  word.alu_func = 4'h8;
                        OP_MUL:  word.alu_func = 4'h9;
                        OP_ROL:  word.alu_func = 4'hA;
                        OP_ROR:  word.alu_func = 4'hB;
                        default: word.alu_func = 4'h0;
                endcase

                if (dec.opcode == OP_CMP || dec.opcode == OP_TEST)
                        word.wb = WB_NONE;

                if (dec.opcode == OP_MVRR) begin
                        word.alu_in_sel = IN_SRC;
                        word.sst        = SST_KEEP;     // plain move keeps flags
                end else if (dec.opcode inside {OP_DEC, OP_INC, OP_SHL, OP_SHR}) begin
                        word.alu_in_sel = IN_DST;       // single operand
                end

                if (dec.opcode == OP_DEC || dec.opcode == OP_INC)
                        word.sci = SCI_ONE;
                else if (dec.opcode >= OP_ADC)
                        word.sci = SCI_FLAG;
        end

endmodule

// ==== design/branch_decode.sv ====
`timescale 1ns/100ps

module branch_decode (
        decode_if.dst               dec,
        input  logic                c,
        input  logic                z,
        input  logic                s,
        output ctrl_pkg::ctrl_word_t word,
        output logic                hit
);
        import isa_pkg::*;
        import ctrl_pkg::*;

        logic is_jump;
        logic taken;
        logic is_flag_op;

        always_comb begin
                is_jump = 1'b1;
                taken   = 1'b0;
                case (dec.opcode)
                        OP_JMP:  taken = 1'b1;
                        OP_JC:   taken = c;
                        OP_JNC:  taken = !c;
                        OP_JZ:   taken = z;
                        OP_JNZ:  taken = !z;
                        OP_JS:   taken = s;
                        OP_JNS:  taken = !s;
                        default: is_jump = 1'b0;
                endcase
        end

        assign is_flag_op = (dec.opcode == OP_STC) || (dec.opcode == OP_CLC);
        assign hit        = (dec.phase == PH_EXEC) && (is_jump || is_flag_op);

        always_comb begin
                word.dest_reg = '0;
                word.sour_reg = '0;
                word.offset   = dec.imm_f;
                word.alu_func = 4'h0;
                word.sci      = SCI_ZERO;
                word.rec      = REC_NONE;
                word.wr       = 1'b1;
                if (is_jump) begin
                        word.alu_in_sel = IN_OFS;       // pc + offset
                        word.sst        = SST_KEEP;
                        word.wb         = taken ? WB_PC : WB_NONE;
                end else begin
                        word.alu_in_sel = IN_NONE;
                        word.wb         = WB_NONE;
                        word.sst        = (dec.opcode == OP_STC) ? SST_SETC : SST_CLRC;
                end
        end

endmodule

// ==== design/controller.sv ====
`timescale 1ns/100ps

module controller (
        input  logic        clk,
        input  logic        arst_n,
        input  logic [2:0]  timer,
        input  logic [15:0] instruction,
        input  logic        c,
        input  logic        z,
        input  logic        s,
        output logic [3:0]  dest_reg,
        output logic [3:0]  sour_reg,
        output logic [7:0]  offset,
        output logic [1:0]  sst,
        output logic [1:0]  sci,
        output logic [1:0]  rec,
        output logic [3:0]  alu_func,
        output logic [2:0]  alu_in_sel,
        output logic        en_reg,
        output logic        en_pc,
        output logic        wr
);
        import ctrl_pkg::*;

        ctrl_word_t alu_word;
        ctrl_word_t br_word;
        ctrl_word_t xf_word;
        ctrl_word_t q;
        logic       alu_hit;
        logic       br_hit;
        logic       xf_hit;

        decode_if dec (.clk(clk), .arst_n(arst_n));

        phase_decode u_phase (
                .timer       (timer),
                .instruction (instruction),
                .dec         (dec)
        );

        alu_op_decode u_alu (.dec(dec), .word(alu_word), .hit(alu_hit));

        branch_decode u_branch (
                .dec  (dec),
                .c    (c),
                .z    (z),
                .s    (s),
                .word (br_word),
                .hit  (br_hit)
        );

        transfer_decode u_xfer (.dec(dec), .word(xf_word), .hit(xf_hit));

        ctrl_select u_sel (
                .clk      (clk),
                .arst_n   (arst_n),
                .dec      (dec),
                .alu_word (alu_word),
                .alu_hit  (alu_hit),
                .br_word  (br_word),
                .br_hit   (br_hit),
                .xf_word  (xf_word),
                .xf_hit   (xf_hit),
                .q        (q)
        );

        assign dest_reg   = q.dest_reg;
        assign sour_reg   = q.sour_reg;
        assign offset     = q.offset;
        assign sst        = q.sst;
        assign sci        = q.sci;
        assign rec        = q.rec;
        assign alu_func   = q.alu_func;
        assign alu_in_sel = q.alu_in_sel;
        assign en_reg     = q.wb[0];    // write-back to register file
        assign en_pc      = q.wb[1];
        assign wr         = q.wr;

endmodule

// ==== design/ctrl_pkg.sv ====
package ctrl_pkg;

        typedef enum logic [1:0] {
                WB_NONE = 2'b00,
                WB_REG  = 2'b01,
                WB_PC   = 2'b10
        } wb_sel_t;

        typedef enum logic [2:0] {
                IN_NONE = 3'd0,
                IN_SRC  = 3'd1,
                IN_DST  = 3'd2,
                IN_OFS  = 3'd3,
                IN_PC   = 3'd4,
                IN_MEM  = 3'd5
        } in_sel_t;

        typedef enum logic [1:0] {
                SST_ALU  = 2'b00,
                SST_SETC = 2'b01,
                SST_CLRC = 2'b10,
                SST_KEEP = 2'b11
        } sst_t;

        typedef enum logic [1:0] {
                SCI_ZERO = 2'b00,
                SCI_ONE  = 2'b01,
                SCI_FLAG = 2'b10        // carry in from c flag
        } sci_t;

        typedef enum logic [1:0] {
                REC_NONE  = 2'b00,
                REC_FETCH = 2'b01,
                REC_READ  = 2'b10,
                REC_DATA  = 2'b11
        } rec_t;

        typedef logic [3:0] alu_func_t;

        typedef struct packed {
                isa_pkg::reg_idx_t dest_reg;
                isa_pkg::reg_idx_t sour_reg;
                isa_pkg::imm_t     offset;
                sst_t              sst;
                sci_t              sci;
                rec_t              rec;
                alu_func_t         alu_func;
                in_sel_t           alu_in_sel;
                wb_sel_t           wb;
                logic              wr;          // active low
        } ctrl_word_t;

        localparam ctrl_word_t CTRL_IDLE = '{
                dest_reg:   '0,
                sour_reg:   '0,
                offset:     '0,
                sst:        SST_KEEP,
                sci:        SCI_ZERO,
                rec:        REC_NONE,
                alu_func:   '0,
                alu_in_sel: IN_NONE,
                wb:         WB_NONE,
                wr:         1'b1
        };

endpackage

// ==== design/ctrl_select.sv ====
`timescale 1ns/100ps

module ctrl_select (
        input  logic                 clk,
        input  logic                 arst_n,
        decode_if.dst                dec,
        input  ctrl_pkg::ctrl_word_t alu_word,
        input  logic                 alu_hit,
        input  ctrl_pkg::ctrl_word_t br_word,
        input  logic                 br_hit,
        input  ctrl_pkg::ctrl_word_t xf_word,
        input  logic                 xf_hit,
        output ctrl_pkg::ctrl_word_t q
);
        import isa_pkg::*;
        import ctrl_pkg::*;

        ctrl_word_t nxt;
        logic       is_fetch;
        logic       load;

        always_comb begin
                is_fetch = 1'b1;
                nxt      = CTRL_IDLE;
                case (dec.phase)
                        PH_FETCH0: nxt = CTRL_IDLE;
                        PH_FETCH1: begin
                                nxt.sci        = SCI_ONE;       // pc increment
                                nxt.alu_in_sel = IN_PC;
                                nxt.wb         = WB_PC;
                                nxt.rec        = REC_FETCH;
                        end
                        PH_FETCH2: nxt.rec = REC_READ;
                        default: begin
                                is_fetch = 1'b0;
                                if (alu_hit)
                                        nxt = alu_word;
                                else if (br_hit)
                                        nxt = br_word;
                                else
                                        nxt = xf_word;
                        end
                endcase
        end

        assign load = dec.phase_ok && (is_fetch || alu_hit || br_hit || xf_hit);

        always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n)
                        q <= CTRL_IDLE;
                else if (load)
                        q <= nxt;       // otherwise hold last word
        end

        // decoders cover disjoint opcode and phase ranges
        single_hit: assert property (
                @(posedge clk) disable iff (!arst_n)
                $onehot0({alu_hit, br_hit, xf_hit})
        );

endmodule

// ==== design/decode_if.sv ====
`timescale 1ns/100ps

interface decode_if (
        input logic clk,
        input logic arst_n
);
        import isa_pkg::*;

        phase_t   phase;
        logic     phase_ok;     // timer holds a known phase code
        opcode_t  opcode;
        reg_idx_t dest_f;
        reg_idx_t sour_f;
        imm_t     imm_f;

        modport src (
                input  clk,
                input  arst_n,
                output phase,
                output phase_ok,
                output opcode,
                output dest_f,
                output sour_f,
                output imm_f
        );

        modport dst (
                input phase,
                input phase_ok,
                input opcode,
                input dest_f,
                input sour_f,
                input imm_f
        );

endinterface

// ==== design/isa_pkg.sv ====
package isa_pkg;

        typedef enum logic [2:0] {
                PH_FETCH1 = 3'b000,
                PH_FETCH2 = 3'b001,
                PH_EXEC   = 3'b011,
                PH_FETCH0 = 3'b100,
                PH_XFER0  = 3'b101,
                PH_XFER1  = 3'b111
        } phase_t;

        typedef logic [7:0] opcode_t;
        typedef logic [3:0] reg_idx_t;
        typedef logic [7:0] imm_t;          // signed branch offset

        localparam int OPC_LSB = 8;
        localparam int DST_LSB = 4;
        localparam int SRC_LSB = 0;
        localparam int IMM_LSB = 0;

        localparam opcode_t OP_ADD  = 8'h00;
        localparam opcode_t OP_SUB  = 8'h01;
        localparam opcode_t OP_AND  = 8'h02;
        localparam opcode_t OP_CMP  = 8'h03;
        localparam opcode_t OP_XOR  = 8'h04;
        localparam opcode_t OP_TEST = 8'h05;
        localparam opcode_t OP_OR   = 8'h06;
        localparam opcode_t OP_MVRR = 8'h07;
        localparam opcode_t OP_DEC  = 8'h08;
        localparam opcode_t OP_INC  = 8'h09;
        localparam opcode_t OP_SHL  = 8'h0A;
        localparam opcode_t OP_SHR  = 8'h0B;
        localparam opcode_t OP_ADC  = 8'h0C;
        localparam opcode_t OP_SBB  = 8'h0D;
        localparam opcode_t OP_NOT  = 8'h0E;
        localparam opcode_t OP_DIV  = 8'h0F;
        localparam opcode_t OP_MUL  = 8'h10;
        localparam opcode_t OP_ROL  = 8'h11;
        localparam opcode_t OP_ROR  = 8'h12;    // last alu opcode

        localparam opcode_t OP_JMP  = 8'h40;
        localparam opcode_t OP_JS   = 8'h41;
        localparam opcode_t OP_JNS  = 8'h43;
        localparam opcode_t OP_JC   = 8'h44;
        localparam opcode_t OP_JNC  = 8'h45;
        localparam opcode_t OP_JZ   = 8'h46;
        localparam opcode_t OP_JNZ  = 8'h47;
        localparam opcode_t OP_STC  = 8'h78;
        localparam opcode_t OP_CLC  = 8'h7A;

        localparam opcode_t OP_JMPA = 8'h80;    // absolute jump, target in next word
        localparam opcode_t OP_MVRD = 8'h81;    // load immediate word
        localparam opcode_t OP_LD   = 8'h82;
        localparam opcode_t OP_ST   = 8'h83;

endpackage

// ==== design/phase_decode.sv ====
`timescale 1ns/100ps

module phase_decode (
        input logic [2:0]  timer,
        input logic [15:0] instruction,
        decode_if.src      dec
);
        import isa_pkg::*;

        assign dec.phase = phase_t'(timer);

        always_comb begin
                case (timer)
                        PH_FETCH0,
                        PH_FETCH1,
                        PH_FETCH2,
                        PH_EXEC,
                        PH_XFER0,
                        PH_XFER1: dec.phase_ok = 1'b1;
                        default:  dec.phase_ok = 1'b0;  // 010, 110 unused
                endcase
        end

        assign dec.opcode = instruction[OPC_LSB +: $bits(opcode_t)];
        assign dec.dest_f = instruction[DST_LSB +: $bits(reg_idx_t)];
        assign dec.sour_f = instruction[SRC_LSB +: $bits(reg_idx_t)];
        assign dec.imm_f  = instruction[IMM_LSB +: $bits(imm_t)];

        // a stray X on timer would freeze the control word unnoticed
        phase_known: assert property (
                @(posedge dec.clk) disable iff (!dec.arst_n)
                !$isunknown(timer)
        );

endmodule

// ==== design/transfer_decode.sv ====
`timescale 1ns/100ps

module transfer_decode (
        decode_if.dst               dec,
        output ctrl_pkg::ctrl_word_t word,
        output logic                hit
);
        import isa_pkg::*;
        import ctrl_pkg::*;

        logic is_xfer;

        assign is_xfer = dec.opcode inside {OP_JMPA, OP_MVRD, OP_LD, OP_ST};
        assign hit     = is_xfer && (dec.phase == PH_XFER0 || dec.phase == PH_XFER1);

        always_comb begin
                word.dest_reg   = dec.dest_f;
                word.sour_reg   = dec.sour_f;
                word.offset     = '0;
                word.sst        = SST_KEEP;
                word.alu_func   = 4'h0;
                word.sci        = SCI_ZERO;
                word.rec        = REC_NONE;
                word.wr         = 1'b1;
                word.alu_in_sel = IN_NONE;
                word.wb         = WB_NONE;

                if (dec.phase == PH_XFER0) begin
                        case (dec.opcode)
                                OP_JMPA, OP_MVRD: begin
                                        word.sci        = SCI_ONE;      // pc + 1 past operand
                                        word.alu_in_sel = IN_PC;
                                        word.wb         = WB_PC;
                                        word.rec        = REC_FETCH;
                                end
                                OP_LD: begin
                                        word.alu_in_sel = IN_SRC;       // address from source
                                        word.rec        = REC_DATA;
                                end
                                OP_ST: begin
                                        word.alu_in_sel = IN_DST;
                                        word.rec        = REC_DATA;
                                end
                                default: ;
                        endcase
                end else begin
                        case (dec.opcode)
                                OP_MVRD, OP_LD: begin
                                        word.alu_in_sel = IN_MEM;
                                        word.wb         = WB_REG;
                                end
                                OP_JMPA: begin
                                        word.alu_in_sel = IN_MEM;
                                        word.wb         = WB_PC;
                                end
                                OP_ST: begin
                                        word.alu_in_sel = IN_SRC;
                                        word.wr         = 1'b0;         // memory write strobe
                                end
                                default: ;
                        endcase
                end
        end

endmodule

// ==== run.sh ====
#!/bin/sh
# compile with Verilator and run the controller testbench
set -e
verilator --binary --timing --assert --timescale 1ns/100ps \
        --top-module controller_tb -f build.f -o controller_sim
./obj_dir/controller_sim > sim.log 2>&1
cat sim.log
if grep -q "ERRORS FOUND" sim.log; then
        echo "simulation failed"
        exit 1
fi
echo "simulation passed"

// ==== testbench/controller_tb.sv ====
`timescale 1ns/100ps

module controller_tb;

        localparam int PERIOD       = 40;
        localparam int RESET_CYCLES = 4;
        localparam int JUMP_RUNS    = 20;
        // reset, fetch, alu sweep, jumps, carry ops, transfers, hold cases
        localparam int TEST_CYCLES  = RESET_CYCLES + 3 + 19 + 7 * JUMP_RUNS + 2 + 8 + 6;
        localparam int TIMEOUT_NS   = (TEST_CYCLES + 20) * PERIOD;

        localparam logic [2:0] T_F0 = 3'b100;
        localparam logic [2:0] T_F1 = 3'b000;
        localparam logic [2:0] T_F2 = 3'b001;
        localparam logic [2:0] T_EX = 3'b011;
        localparam logic [2:0] T_X0 = 3'b101;
        localparam logic [2:0] T_X1 = 3'b111;

        // sst keep and wr high, everything else zero
        localparam logic [31:0] IDLE_W = {4'h0, 4'h0, 8'h00, 2'b11, 2'b00, 2'b00, 4'h0,
                                          3'd0, 2'b00, 1'b1};

        logic        clk = 1'b0;
        logic        arst_n;
        logic [2:0]  timer;
        logic [15:0] instruction;
        logic        c, z, s;
        logic [3:0]  dest_reg, sour_reg, alu_func;
        logic [7:0]  offset;
        logic [1:0]  sst, sci, rec;
        logic [2:0]  alu_in_sel;
        logic        en_reg, en_pc, wr;
        logic [31:0] expected;
        logic [31:0] out_word;
        integer      seed;
        int          errors = 0;
        int          checks = 0;

        controller DUT (.*);

        assign out_word = {dest_reg, sour_reg, offset, sst, sci, rec, alu_func, alu_in_sel,
                           en_pc, en_reg, wr};

        always #(PERIOD / 2) clk = ~clk;

        function automatic logic [31:0] make_word(input logic [3:0] d, input logic [3:0] sr,
                        input logic [7:0] o, input logic [1:0] st, input logic [1:0] sc,
                        input logic [1:0] rc, input logic [3:0] f, input logic [2:0] isel,
                        input logic [1:0] wb, input logic w);
                return {d, sr, o, st, sc, rc, f, isel, wb, w};
        endfunction

        function automatic logic jump_taken(input logic [7:0] op, input logic [2:0] czs);
                case (op)
                        8'h44:   return czs[2];
                        8'h45:   return !czs[2];
                        8'h46:   return czs[1];
                        8'h47:   return !czs[1];
                        8'h41:   return czs[0];
                        8'h43:   return !czs[0];
                        default: return 1'b1;   // 0x40 unconditional
                endcase
        endfunction

        function automatic logic [31:0] alu_expect(input logic [7:0] op, input logic [3:0] d,
                        input logic [3:0] sr);
                logic [12:0] row;       // alu_func, in_sel, sst, sci, wb
                case (op)
                        8'h00:   row = {4'h0, 3'd0, 2'b00, 2'b00, 2'b01};
                        8'h01:   row = {4'h1, 3'd0, 2'b00, 2'b00, 2'b01};
                        8'h02:   row = {4'h2, 3'd0, 2'b00, 2'b00, 2'b01};
                        8'h03:   row = {4'h1, 3'd0, 2'b00, 2'b00, 2'b00};
                        8'h04:   row = {4'h4, 3'd0, 2'b00, 2'b00, 2'b01};
                        8'h05:   row = {4'h2, 3'd0, 2'b00, 2'b00, 2'b00};
                        8'h06:   row = {4'h3, 3'd0, 2'b00, 2'b00, 2'b01};
                        8'h07:   row = {4'h0, 3'd1, 2'b11, 2'b00, 2'b01};
                        8'h08:   row = {4'h1, 3'd2, 2'b00, 2'b01, 2'b01};
                        8'h09:   row = {4'h0, 3'd2, 2'b00, 2'b01, 2'b01};
                        8'h0A:   row = {4'h5, 3'd2, 2'b00, 2'b00, 2'b01};
                        8'h0B:   row = {4'h6, 3'd2, 2'b00, 2'b00, 2'b01};
                        8'h0C:   row = {4'h0, 3'd0, 2'b00, 2'b10, 2'b01};
                        8'h0D:   row = {4'h1, 3'd0, 2'b00, 2'b10, 2'b01};
                        8'h0E:   row = {4'h7, 3'd0, 2'b00, 2'b10, 2'b01};
                        8'h0F:   row = {4'h8, 3'd0, 2'b00, 2'b10, 2'b01};
                        8'h10:   row = {4'h9, 3'd0, 2'b00, 2'b10, 2'b01};
                        8'h11:   row = {4'hA, 3'd0, 2'b00, 2'b10, 2'b01};
                        8'h12:   row = {4'hB, 3'd0, 2'b00, 2'b10, 2'b01};
                        default: row = {4'h0, 3'd0, 2'b00, 2'b00, 2'b01};
                endcase
                return make_word(d, sr, 8'h00, row[5:4], row[3:2], 2'b00, row[12:9],
                                 row[8:6], row[1:0], 1'b1);
        endfunction

        // expected registered word; prev is kept when nothing is recognised
        function automatic logic [31:0] ref_word(input logic [2:0] tmr, input logic [15:0] ins,
                        input logic [2:0] czs, input logic [31:0] prev);
                logic [7:0] op;
                logic [3:0] d;
                logic [3:0] sr;
                op = ins[15:8];
                d = ins[7:4];
                sr = ins[3:0];
                ref_word = prev;
                case (tmr)
                        T_F0: ref_word = IDLE_W;
                        T_F1: ref_word = make_word(4'h0, 4'h0, 8'h00, 2'b11, 2'b01, 2'b01,
                                                   4'h0, 3'd4, 2'b10, 1'b1);
                        T_F2: ref_word = make_word(4'h0, 4'h0, 8'h00, 2'b11, 2'b00, 2'b10,
                                                   4'h0, 3'd0, 2'b00, 1'b1);
                        T_EX: begin
                                if (op <= 8'h12)
                                        ref_word = alu_expect(op, d, sr);
                                else if (op inside {8'h40, 8'h41, 8'h43, 8'h44, 8'h45, 8'h46,
                                                    8'h47})
                                        ref_word = make_word(4'h0, 4'h0, ins[7:0], 2'b11,
                                                2'b00, 2'b00, 4'h0, 3'd3,
                                                jump_taken(op, czs) ? 2'b10 : 2'b00, 1'b1);
                                else if (op == 8'h78 || op == 8'h7A)
                                        ref_word = make_word(4'h0, 4'h0, ins[7:0],
                                                (op == 8'h78) ? 2'b01 : 2'b10, 2'b00, 2'b00,
                                                4'h0, 3'd0, 2'b00, 1'b1);
                        end
                        T_X0: case (op)
                                8'h80, 8'h81: ref_word = make_word(d, sr, 8'h00, 2'b11, 2'b01,
                                                2'b01, 4'h0, 3'd4, 2'b10, 1'b1);
                                8'h82: ref_word = make_word(d, sr, 8'h00, 2'b11, 2'b00, 2'b11,
                                                4'h0, 3'd1, 2'b00, 1'b1);
                                8'h83: ref_word = make_word(d, sr, 8'h00, 2'b11, 2'b00, 2'b11,
                                                4'h0, 3'd2, 2'b00, 1'b1);
                                default: ;
                        endcase
                        T_X1: case (op)
                                8'h81, 8'h82: ref_word = make_word(d, sr, 8'h00, 2'b11, 2'b00,
                                                2'b00, 4'h0, 3'd5, 2'b01, 1'b1);
                                8'h80: ref_word = make_word(d, sr, 8'h00, 2'b11, 2'b00, 2'b00,
                                                4'h0, 3'd5, 2'b10, 1'b1);
                                8'h83: ref_word = make_word(d, sr, 8'h00, 2'b11, 2'b00, 2'b00,
                                                4'h0, 3'd1, 2'b00, 1'b0);
                                default: ;
                        endcase
                        default: ;      // 010 and 110 hold
                endcase
        endfunction

        task automatic check(input string name);
                checks++;
                assert (out_word === expected) else begin
                        $display("ERROR %s: expected %h, actual %h", name, expected, out_word);
                        errors++;
                end
        endtask

        // entered 5 ns after an edge, returns 5 ns after the next one
        task automatic step(input logic [2:0] tmr, input logic [15:0] ins,
                        input logic [2:0] czs, input string name);
                timer = tmr;
                instruction = ins;
                {c, z, s} = czs;
                expected = ref_word(tmr, ins, czs, expected);
                @(posedge clk);
                #5;
                check(name);
        endtask

        task automatic report_test(input string name, input int first_err);
                $display("test %-8s finished with %0d errors", name, errors - first_err);
        endtask

        task automatic reset_test();
                int first;
                first = errors;
                repeat (RESET_CYCLES - 1) @(posedge clk);
                #5;
                check("reset");
                @(posedge clk);
                #5;
                arst_n = 1'b1;
                check("reset");
                report_test("reset", first);
        endtask

        task automatic fetch_test();
                int first;
                first = errors;
                step(T_F0, 16'h1234, 3'b000, "fetch0");
                step(T_F1, 16'h1234, 3'b000, "fetch1");
                step(T_F2, 16'h1234, 3'b000, "fetch2");
                report_test("fetch", first);
        endtask

        task automatic alu_test();
                int          first;
                logic [31:0] rnd;
                first = errors;
                for (logic [7:0] op = 8'h00; op <= 8'h12; op++) begin
                        rnd = $random(seed);
                        step(T_EX, {op, rnd[7:0]}, 3'b000, "alu");
                end
                report_test("alu", first);
        endtask

        task automatic jump_test();
                int          first;
                logic [31:0] rnd;
                logic [7:0]  jumps [0:6];
                first = errors;
                jumps = '{8'h40, 8'h41, 8'h43, 8'h44, 8'h45, 8'h46, 8'h47};
                foreach (jumps[i]) begin
                        repeat (JUMP_RUNS) begin
                                rnd = $random(seed);
                                step(T_EX, {jumps[i], rnd[7:0]}, rnd[10:8], "jump");
                                checks++;
                                assert (en_pc === jump_taken(jumps[i], rnd[10:8])) else begin
                                        $display("ERROR jump en_pc: expected %b, actual %b",
                                                 jump_taken(jumps[i], rnd[10:8]), en_pc);
                                        errors++;
                                end
                        end
                end
                step(T_EX, 16'h7800, 3'b000, "stc");
                checks++;
                assert (sst === 2'b01) else begin
                        $display("ERROR stc sst: expected %b, actual %b", 2'b01, sst);
                        errors++;
                end
                step(T_EX, 16'h7A00, 3'b000, "clc");
                checks++;
                assert (sst === 2'b10) else begin
                        $display("ERROR clc sst: expected %b, actual %b", 2'b10, sst);
                        errors++;
                end
                report_test("jump", first);
        endtask

        task automatic xfer_test();
                int          first;
                logic [31:0] rnd;
                first = errors;
                for (logic [7:0] op = 8'h80; op <= 8'h83; op++) begin
                        rnd = $random(seed);
                        step(T_X0, {op, rnd[7:0]}, 3'b000, "xfer0");
                        step(T_X1, {op, rnd[7:0]}, 3'b000, "xfer1");
                        checks++;
                        assert (wr === (op != 8'h83)) else begin
                                $display("ERROR xfer1 wr: expected %b, actual %b",
                                         op != 8'h83, wr);
                                errors++;
                        end
                end
                report_test("xfer", first);
        endtask

        task automatic hold_test();
                int          first;
                logic [31:0] held;
                first = errors;
                held = alu_expect(8'h0C, 4'h5, 4'hA);   // adc word loaded first
                step(T_EX, 16'h0C5A, 3'b000, "hold");
                step(T_EX, 16'h8412, 3'b000, "hold");
                step(T_EX, 16'h2034, 3'b000, "hold");
                step(3'b010, 16'h0156, 3'b000, "hold");
                step(3'b110, 16'h0478, 3'b000, "hold");
                step(T_X0, 16'h2099, 3'b000, "hold");
                checks++;
                assert (out_word === held) else begin
                        $display("ERROR hold: expected %h, actual %h", held, out_word);
                        errors++;
                end
                report_test("hold", first);
        endtask

        initial begin
                seed = 32'hea5d;
                arst_n = 1'b0;
                timer = T_F0;
                instruction = 16'h0000;
                c = 1'b0;
                z = 1'b0;
                s = 1'b0;
                expected = IDLE_W;
                reset_test();
                fetch_test();
                alu_test();
                jump_test();
                xfer_test();
                hold_test();
                $display("checks %0d, errors %0d", checks, errors);
                if (errors == 0)
                        $display("NO ERRORS");
                else
                        $display("ERRORS FOUND");
                $finish;
        end

        initial begin   // watchdog
                #(TIMEOUT_NS);
                $display("timeout: tests did not finish within %0d ns", TIMEOUT_NS);
                $display("ERRORS FOUND");
                $finish;
        end

endmodule
